//--- common/SchedulerTypes.sv
// scheduler widths and typedefs
// op tag, physical register tag, queue index and one-hot entry mask
// helper for the mask of live entries

package SchedulerTypes;

    // upper bound on entries, sizes index and one-hot types
    localparam int QUEUE_DEPTH_MAX = 16;

    localparam int QUEUE_INDEX_WIDTH = $clog2(QUEUE_DEPTH_MAX);
    localparam int OP_TAG_WIDTH      = 8;
    localparam int PHY_REG_TAG_WIDTH = 6;

    // micro-op identifier, dispatch to issue
    typedef logic [OP_TAG_WIDTH-1:0] OpTagPath;

    // source operand and wakeup broadcast tag
    typedef logic [PHY_REG_TAG_WIDTH-1:0] PhyRegTagPath;

    typedef logic [QUEUE_INDEX_WIDTH-1:0] IssueQueueIndexPath;

    // one bit per entry: free, flush and issued masks
    typedef logic [QUEUE_DEPTH_MAX-1:0] IssueQueueOneHotPath;

    // ones on the entries that exist for a given depth
    function automatic IssueQueueOneHotPath liveEntryMask(input int depth);
        IssueQueueOneHotPath mask;
        mask = '0;
        for (int e = 0; e < QUEUE_DEPTH_MAX; e++) begin
            if (e < depth) begin
                mask[e] = 1'b1;
            end
        end
        return mask;
    endfunction

endpackage : SchedulerTypes

//--- common/DispatchIF.sv
// entry allocation bus, dispatch unit to issue queue
// free mask back from the queue

`timescale 1ns/1ps

interface DispatchIF import SchedulerTypes::*; ();

    IssueQueueOneHotPath freeMask;    // from queue, one bit per empty entry

    logic               write;        // one-cycle load strobe
    IssueQueueIndexPath writePtr;
    OpTagPath           writeTag;
    PhyRegTagPath       writeSrcTag;
    logic               writeSrcReady;

    modport Dispatch (
        input  freeMask,
        output write,
        output writePtr,
        output writeTag,
        output writeSrcTag,
        output writeSrcReady
    );

    modport Queue (
        output freeMask,
        input  write,
        input  writePtr,
        input  writeTag,
        input  writeSrcTag,
        input  writeSrcReady
    );

endinterface : DispatchIF

//--- common/SchedulerIF.sv
// select and issue bus between issue queue and schedule stage
// selected slots forward, issued entry mask back

`timescale 1ns/1ps

interface SchedulerIF import SchedulerTypes::*; #(
    parameter int issueWidth = 2
) ();

    // per issue slot, lowest index in slot 0
    logic               selected    [issueWidth];
    IssueQueueIndexPath selectedPtr [issueWidth];
    OpTagPath           selectedTag [issueWidth];

    IssueQueueOneHotPath issuedMask;  // freed on next edge

    modport Queue (
        output selected,
        output selectedPtr,
        output selectedTag,
        input  issuedMask
    );

    modport ScheduleStage (
        input  selected,
        input  selectedPtr,
        input  selectedTag,
        output issuedMask
    );

endinterface : SchedulerIF

//--- scheduler/DispatchUnit.sv
// dispatch unit: lowest free entry search, full flag,
// write strobe and same-cycle wakeup bypass

`timescale 1ns/1ps

module DispatchUnit import SchedulerTypes::*; #(
    parameter int queueDepth = 8
) (
    input  logic         clk,
    input  logic         arstN,
    input  logic         dispatchValid,
    input  OpTagPath     dispatchTag,
    input  PhyRegTagPath dispatchSrcTag,
    input  logic         dispatchSrcReady,
    input  logic         wakeupValid,
    input  PhyRegTagPath wakeupTag,
    output logic         dispatchFull,
    DispatchIF.Dispatch  dispatch
);

    IssueQueueOneHotPath candidates;
    IssueQueueIndexPath  freePtr;
    logic                anyFree;
    logic                wakeupHit;

    always_comb begin
        candidates = dispatch.freeMask & liveEntryMask(queueDepth);

        // priority encoder, lowest index wins
        freePtr = '0;
        anyFree = 1'b0;
        for (int e = QUEUE_DEPTH_MAX - 1; e >= 0; e--) begin
            if (candidates[e]) begin
                freePtr = IssueQueueIndexPath'(e);
                anyFree = 1'b1;
            end
        end
    end

    assign dispatchFull = !anyFree;

    // broadcast in the same cycle counts as ready
    assign wakeupHit = wakeupValid && (wakeupTag == dispatchSrcTag);

    assign dispatch.write         = dispatchValid && anyFree;
    assign dispatch.writePtr      = freePtr;
    assign dispatch.writeTag      = dispatchTag;
    assign dispatch.writeSrcTag   = dispatchSrcTag;
    assign dispatch.writeSrcReady = dispatchSrcReady || wakeupHit;

endmodule : DispatchUnit

//--- scheduler/IssueQueue.sv
// issue queue: entry storage with one source operand each,
// wakeup match, flush and issue freeing,
// lowest-index-first select of up to issueWidth ready entries

`timescale 1ns/1ps

module IssueQueue import SchedulerTypes::*; #(
    parameter int queueDepth = 8,
    parameter int issueWidth = 2
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic                wakeupValid,
    input  PhyRegTagPath        wakeupTag,
    input  IssueQueueOneHotPath flushMask,
    DispatchIF.Queue            dispatch,
    SchedulerIF.Queue           scheduler
);

    // control state per entry
    logic [queueDepth-1:0] entryValid;
    logic [queueDepth-1:0] entrySrcReady;

    // payload per entry
    OpTagPath     entryTag    [queueDepth];
    PhyRegTagPath entrySrcTag [queueDepth];

    logic [queueDepth-1:0] writeHit;    // entry loaded this edge
    logic [queueDepth-1:0] wakeupHit;   // waiting entry matches broadcast
    logic [queueDepth-1:0] releaseHit;  // flushed or issued

    always_comb begin
        for (int e = 0; e < queueDepth; e++) begin
            writeHit[e]   = dispatch.write && (dispatch.writePtr == IssueQueueIndexPath'(e));
            wakeupHit[e]  = wakeupValid && entryValid[e] && (entrySrcTag[e] == wakeupTag);
            releaseHit[e] = flushMask[e] || scheduler.issuedMask[e];
        end
    end

    // empty entries back to dispatch, unused upper bits stay zero
    always_comb begin
        dispatch.freeMask = '0;
        for (int e = 0; e < queueDepth; e++) begin
            dispatch.freeMask[e] = !entryValid[e];
        end
    end

    // load, then wakeup, then release; later step wins
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            entryValid    <= '0;
            entrySrcReady <= '0;
        end else begin
            for (int e = 0; e < queueDepth; e++) begin
                if (writeHit[e]) begin
                    entryValid[e]    <= 1'b1;
                    entrySrcReady[e] <= dispatch.writeSrcReady;
                end else if (wakeupHit[e]) begin
                    entrySrcReady[e] <= 1'b1;
                end

                if (releaseHit[e]) begin
                    entryValid[e] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < queueDepth; e++) begin
            if (writeHit[e]) begin
                entryTag[e]    <= dispatch.writeTag;
                entrySrcTag[e] <= dispatch.writeSrcTag;
            end
        end
    end

    // select walks from index 0, fills slots in order
    always_comb begin
        int slot;
        slot = 0;
        for (int s = 0; s < issueWidth; s++) begin
            scheduler.selected[s]    = 1'b0;
            scheduler.selectedPtr[s] = '0;
            scheduler.selectedTag[s] = '0;
        end
        for (int e = 0; e < queueDepth; e++) begin
            if (entryValid[e] && entrySrcReady[e] && slot < issueWidth) begin
                scheduler.selected[slot]    = 1'b1;
                scheduler.selectedPtr[slot] = IssueQueueIndexPath'(e);
                scheduler.selectedTag[slot] = entryTag[e];
                slot++;
            end
        end
    end

endmodule : IssueQueue

//--- scheduler/ScheduleStage.sv
// schedule stage: masks the selection with stall, clear and flush,
// returns the issued mask and holds the issue-stage register

`timescale 1ns/1ps

module ScheduleStage import SchedulerTypes::*; #(
    parameter int queueDepth = 8,
    parameter int issueWidth = 2
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic                stall,
    input  logic                clear,
    input  IssueQueueOneHotPath flushMask,
    SchedulerIF.ScheduleStage   scheduler,
    output logic                issueValid [issueWidth],
    output OpTagPath            issueTag   [issueWidth],
    output IssueQueueIndexPath  issuePtr   [issueWidth]
);

    IssueQueueOneHotPath liveFlush;
    logic flush     [issueWidth];
    logic update    [issueWidth];
    logic nextValid [issueWidth];

    always_comb begin
        liveFlush            = flushMask & liveEntryMask(queueDepth);
        scheduler.issuedMask = '0;

        for (int i = 0; i < issueWidth; i++) begin
            flush[i] = liveFlush[scheduler.selectedPtr[i]];

            // slot really leaves the queue
            update[i] = !stall && !clear && scheduler.selected[i] && !flush[i];

            nextValid[i] = (stall || clear || flush[i]) ? 1'b0 : scheduler.selected[i];

            if (update[i]) begin
                scheduler.issuedMask[scheduler.selectedPtr[i]] = 1'b1;
            end
        end
    end

    // issue-stage register, holds under stall
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < issueWidth; i++) begin
                issueValid[i] <= 1'b0;
            end
        end else if (!stall) begin
            for (int i = 0; i < issueWidth; i++) begin
                issueValid[i] <= nextValid[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int i = 0; i < issueWidth; i++) begin
                issueTag[i] <= scheduler.selectedTag[i];
                issuePtr[i] <= scheduler.selectedPtr[i];  // meaningful only with issueValid
            end
        end
    end

endmodule : ScheduleStage

//--- source/SchedulerUnit.sv
// scheduler top level
// dispatch unit, issue queue and schedule stage joined by two buses

`timescale 1ns/1ps

module SchedulerUnit import SchedulerTypes::*; #(
    parameter int queueDepth = 8,   // at most QUEUE_DEPTH_MAX
    parameter int issueWidth = 2
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic                dispatchValid,
    input  OpTagPath            dispatchTag,
    input  PhyRegTagPath        dispatchSrcTag,
    input  logic                dispatchSrcReady,
    input  logic                wakeupValid,
    input  PhyRegTagPath        wakeupTag,
    input  IssueQueueOneHotPath flushMask,
    input  logic                stall,
    input  logic                clear,
    output logic                dispatchFull,
    output logic                issueValid [issueWidth],
    output OpTagPath            issueTag   [issueWidth],
    output IssueQueueIndexPath  issuePtr   [issueWidth]
);

    DispatchIF dispatchIf ();
    SchedulerIF #(.issueWidth(issueWidth)) schedulerIf ();

    DispatchUnit #(
        .queueDepth (queueDepth)
    ) DispatchUnit_i (
        .clk              (clk),
        .arstN            (arstN),
        .dispatchValid    (dispatchValid),
        .dispatchTag      (dispatchTag),
        .dispatchSrcTag   (dispatchSrcTag),
        .dispatchSrcReady (dispatchSrcReady),
        .wakeupValid      (wakeupValid),
        .wakeupTag        (wakeupTag),
        .dispatchFull     (dispatchFull),
        .dispatch         (dispatchIf.Dispatch)
    );

    IssueQueue #(
        .queueDepth (queueDepth),
        .issueWidth (issueWidth)
    ) IssueQueue_i (
        .clk         (clk),
        .arstN       (arstN),
        .wakeupValid (wakeupValid),
        .wakeupTag   (wakeupTag),
        .flushMask   (flushMask),
        .dispatch    (dispatchIf.Queue),
        .scheduler   (schedulerIf.Queue)
    );

    ScheduleStage #(
        .queueDepth (queueDepth),
        .issueWidth (issueWidth)
    ) ScheduleStage_i (
        .clk        (clk),
        .arstN      (arstN),
        .stall      (stall),
        .clear      (clear),
        .flushMask  (flushMask),
        .scheduler  (schedulerIf.ScheduleStage),
        .issueValid (issueValid),
        .issueTag   (issueTag),
        .issuePtr   (issuePtr)
    );

endmodule : SchedulerUnit

//--- tb/ClockGen.sv
// testbench clock and active-low reset generator

`timescale 1ns/1ps

module ClockGen #(
    parameter real periodNs    = 8.0,
    parameter int  resetCycles = 10
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2.0) clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;  // released on a rising edge
    end

endmodule : ClockGen

//--- tb/SchedulerUnitTb.sv
// testbench for the scheduler top level
// directed tests, entry occupancy model, compare tasks, timeout

`timescale 1ns/1ps

module SchedulerUnitTb import SchedulerTypes::*; ();

    localparam int DEPTH        = 8;
    localparam int WIDTH        = 2;
    localparam int RESET_CYCLES = 10;
    // reset, then rising edges taken by each test in run order
    localparam int TEST_CYCLES  = RESET_CYCLES + 7 + 19 + 13 + 24 + 21 + 25;
    localparam int CYCLE_LIMIT  = TEST_CYCLES + 20;

    logic                clk;
    logic                arstN;
    logic                dispatchValid;
    OpTagPath            dispatchTag;
    PhyRegTagPath        dispatchSrcTag;
    logic                dispatchSrcReady;
    logic                wakeupValid;
    PhyRegTagPath        wakeupTag;
    IssueQueueOneHotPath flushMask;
    logic                stall;
    logic                clear;
    logic                dispatchFull;
    logic                issueValid [WIDTH];
    OpTagPath            issueTag   [WIDTH];
    IssueQueueIndexPath  issuePtr   [WIDTH];

    // occupancy model
    logic         mValid [DEPTH];
    logic         mReady [DEPTH];
    OpTagPath     mTag   [DEPTH];
    PhyRegTagPath mSrc   [DEPTH];

    int          errorCount = 0;
    int          checkCount = 0;
    int          cycles     = 0;
    logic [31:0] rngState   = 32'h6d7e;

    ClockGen #(.periodNs(8.0), .resetCycles(RESET_CYCLES)) ClockGen_i (
        .clk(clk), .arstN(arstN)
    );

    SchedulerUnit #(.queueDepth(DEPTH), .issueWidth(WIDTH)) SchedulerUnit_i (
        .clk(clk), .arstN(arstN),
        .dispatchValid(dispatchValid), .dispatchTag(dispatchTag),
        .dispatchSrcTag(dispatchSrcTag), .dispatchSrcReady(dispatchSrcReady),
        .wakeupValid(wakeupValid), .wakeupTag(wakeupTag),
        .flushMask(flushMask), .stall(stall), .clear(clear),
        .dispatchFull(dispatchFull),
        .issueValid(issueValid), .issueTag(issueTag), .issuePtr(issuePtr)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped, no finish after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic OpTagPath nextTag();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return OpTagPath'(rngState);
    endfunction

    function automatic int lowestFree();
        for (int e = 0; e < DEPTH; e++) begin
            if (!mValid[e]) return e;
        end
        return -1;
    endfunction

    // n-th ready entry counting from index 0, -1 if none
    function automatic int nthReady(input int n);
        int seen;
        seen = 0;
        for (int e = 0; e < DEPTH; e++) begin
            if (mValid[e] && mReady[e]) begin
                if (seen == n) return e;
                seen++;
            end
        end
        return -1;
    endfunction

    task automatic compareBit(input string name, input logic exp, input logic act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
        end
    endtask

    task automatic compareTag(input string name, input OpTagPath exp, input OpTagPath act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
        end
    endtask

    task automatic compareIndex(input string name, input IssueQueueIndexPath exp,
                                input IssueQueueIndexPath act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
        end
    endtask

    task automatic driveIdle();
        dispatchValid    <= 1'b0;
        dispatchSrcReady <= 1'b0;
        wakeupValid      <= 1'b0;
        flushMask        <= '0;
        stall            <= 1'b0;
        clear            <= 1'b0;
    endtask

    task automatic applyWakeup(input PhyRegTagPath tag);
        for (int e = 0; e < DEPTH; e++) begin
            if (mValid[e] && mSrc[e] == tag) mReady[e] = 1'b1;
        end
    endtask

    // idx -1 expects an empty slot
    task automatic checkSlot(input int slot, input int idx);
        compareBit($sformatf("issueValid[%0d]", slot), idx >= 0, issueValid[slot]);
        if (idx >= 0) begin
            compareIndex($sformatf("issuePtr[%0d]", slot), idx, issuePtr[slot]);
            compareTag($sformatf("issueTag[%0d]", slot), mTag[idx], issueTag[slot]);
        end
    endtask

    task automatic retire(input int idx);
        if (idx >= 0) mValid[idx] = 1'b0;
    endtask

    // returns just after the sampling edge; idx -1 when the queue was full
    task automatic dispatchOne(input PhyRegTagPath src, input logic ready,
                               input logic wake, output int idx);
        OpTagPath tag;
        tag = nextTag();
        idx = lowestFree();
        @(posedge clk);
        dispatchValid    <= 1'b1;
        dispatchTag      <= tag;
        dispatchSrcTag   <= src;
        dispatchSrcReady <= ready;
        wakeupValid      <= wake;
        wakeupTag        <= src;
        @(posedge clk);
        driveIdle();
        if (wake) applyWakeup(src);
        if (idx >= 0) begin
            mValid[idx] = 1'b1;
            mReady[idx] = ready || wake;
            mTag[idx]   = tag;
            mSrc[idx]   = src;
        end
    endtask

    task automatic wakeup(input PhyRegTagPath tag);
        @(posedge clk);
        wakeupValid <= 1'b1;
        wakeupTag   <= tag;
        @(posedge clk);
        driveIdle();
        applyWakeup(tag);
    endtask

    // one unstalled edge, both slots against the model
    task automatic issueCycleCheck();
        int p0;
        int p1;
        p0 = nthReady(0);
        p1 = nthReady(1);
        @(posedge clk);
        @(negedge clk);
        checkSlot(0, p0);
        checkSlot(1, p1);
        retire(p0);
        retire(p1);
    endtask

    task automatic testReadyDispatch();
        int idx;
        dispatchOne(6'd1, 1'b1, 1'b0, idx);
        issueCycleCheck();
        compareBit("dispatchFull", 1'b0, dispatchFull);
        dispatchOne(6'd1, 1'b1, 1'b0, idx);
        issueCycleCheck();
        issueCycleCheck();
    endtask

    task automatic testWakeup();
        int idx;
        dispatchOne(6'd2, 1'b0, 1'b0, idx);
        dispatchOne(6'd3, 1'b0, 1'b0, idx);
        dispatchOne(6'd4, 1'b0, 1'b0, idx);
        issueCycleCheck();  // nothing ready
        wakeup(6'd3);
        issueCycleCheck();
        dispatchOne(6'd5, 1'b0, 1'b1, idx);  // same-cycle bypass
        issueCycleCheck();
        wakeup(6'd2);
        issueCycleCheck();
        wakeup(6'd4);
        issueCycleCheck();
    endtask

    task automatic testSelectWidth();
        int idx;
        repeat (4) dispatchOne(6'd10, 1'b0, 1'b0, idx);
        wakeup(6'd10);
        repeat (3) issueCycleCheck();
    endtask

    task automatic testStallClear();
        int idx;
        int p0;
        int p1;
        repeat (4) dispatchOne(6'd20, 1'b0, 1'b0, idx);
        wakeup(6'd20);
        p0 = nthReady(0);
        p1 = nthReady(1);
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
        checkSlot(0, p0);
        checkSlot(1, p1);
        retire(p0);
        retire(p1);
        for (int k = 0; k < 2; k++) begin
            @(posedge clk);
            if (k == 1) stall <= 1'b0;
            @(negedge clk);
            checkSlot(0, p0);  // held
            checkSlot(1, p1);
        end
        issueCycleCheck();
        issueCycleCheck();

        repeat (2) dispatchOne(6'd21, 1'b0, 1'b0, idx);
        wakeup(6'd21);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        @(negedge clk);
        checkSlot(0, -1);
        checkSlot(1, -1);
        issueCycleCheck();
        issueCycleCheck();
    endtask

    task automatic testFlush();
        int idxA;
        int idxB;
        int idxC;
        int idx;
        dispatchOne(6'd30, 1'b0, 1'b0, idxA);
        dispatchOne(6'd31, 1'b0, 1'b0, idxB);
        dispatchOne(6'd32, 1'b0, 1'b0, idxC);
        wakeup(6'd31);  // B now selected
        flushMask <= IssueQueueOneHotPath'((1 << idxA) | (1 << idxB));
        @(posedge clk);
        flushMask <= '0;
        retire(idxA);
        retire(idxB);
        @(negedge clk);
        checkSlot(0, -1);
        checkSlot(1, -1);
        issueCycleCheck();
        // freed A and B taken again, seen on issuePtr below
        dispatchOne(6'd33, 1'b0, 1'b0, idx);
        dispatchOne(6'd33, 1'b0, 1'b0, idx);
        wakeup(6'd33);
        issueCycleCheck();
        wakeup(6'd32);
        issueCycleCheck();
        issueCycleCheck();
    endtask

    task automatic testFull();
        int idx;
        repeat (DEPTH) dispatchOne(6'd40, 1'b0, 1'b0, idx);
        @(negedge clk);
        compareBit("dispatchFull", 1'b1, dispatchFull);
        dispatchOne(6'd40, 1'b0, 1'b0, idx);  // dropped, not in the model
        wakeup(6'd40);
        repeat (DEPTH / WIDTH + 1) issueCycleCheck();
        compareBit("dispatchFull", 1'b0, dispatchFull);
    endtask

    initial begin
        dispatchValid    = 1'b0;
        dispatchTag      = '0;
        dispatchSrcTag   = '0;
        dispatchSrcReady = 1'b0;
        wakeupValid      = 1'b0;
        wakeupTag        = '0;
        flushMask        = '0;
        stall            = 1'b0;
        clear            = 1'b0;
        for (int e = 0; e < DEPTH; e++) begin
            mValid[e] = 1'b0;
            mReady[e] = 1'b0;
        end

        wait (arstN === 1'b1);
        @(negedge clk);
        checkSlot(0, -1);
        checkSlot(1, -1);
        compareBit("dispatchFull", 1'b0, dispatchFull);

        testReadyDispatch();
        testWakeup();
        testSelectWidth();
        testStallClear();
        testFlush();
        testFull();

        $display("checks %0d, errors %0d, cycles %0d", checkCount, errorCount, cycles);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : SchedulerUnitTb

//--- sources.f
common/SchedulerTypes.sv
common/DispatchIF.sv
common/SchedulerIF.sv
scheduler/DispatchUnit.sv
scheduler/IssueQueue.sv
scheduler/ScheduleStage.sv
source/SchedulerUnit.sv
tb/ClockGen.sv
tb/SchedulerUnitTb.sv
